//--- breakout_control.f
+incdir+include
source/control_pkg.sv
source/video_pkg.sv
source/input_front.sv
source/paddle_channel.sv
source/video_overlay.sv
source/breakout_control_top.sv
sim/tb_breakout_control.sv

//--- include/paddle_config.svh
`ifndef PADDLE_CONFIG_SVH
`define PADDLE_CONFIG_SVH

// Paddle position range
`define PADDLE_POS_RESET     128
`define PADDLE_POS_MAX       255

// Digital step per frame
`define DIGITAL_STEP_SLOW    4
`define DIGITAL_STEP_FAST    8

// Brick rows for player 1, counted from the left wall
`define ROW_RED_P1_LO        8'd64
`define ROW_RED_P1_HI        8'd71
`define ROW_AMBER_P1_LO      8'd72
`define ROW_AMBER_P1_HI      8'd79
`define ROW_GREEN_P1_LO      8'd80
`define ROW_GREEN_P1_HI      8'd87
`define ROW_YELLOW_P1_LO     8'd88
`define ROW_YELLOW_P1_HI     8'd95

// Mirrored rows for player 2
`define ROW_RED_P2_LO        8'd184
`define ROW_RED_P2_HI        8'd191
`define ROW_AMBER_P2_LO      8'd176
`define ROW_AMBER_P2_HI      8'd183
`define ROW_GREEN_P2_LO      8'd168
`define ROW_GREEN_P2_HI      8'd175
`define ROW_YELLOW_P2_LO     8'd160
`define ROW_YELLOW_P2_HI     8'd167

// Paddle row, single-player layout only
`define ROW_BLUE_LO          8'd211
`define ROW_BLUE_HI          8'd219

// Blanking windows
`define HBLANK_P1_START      8'd224
`define HBLANK_P1_END        8'd24
`define HBLANK_P2_START      8'd232
`define HBLANK_P2_END        8'd32
`define VBLANK_RAW_LO        8'd228
`define VBLANK_RAW_HI        8'd251
`define VBLANK_FX_LO         8'd223
`define VBLANK_FX_HI         8'd252

`endif

//--- sim/tb_breakout_control.sv
`default_nettype none

module tb_breakout_control;
	import control_pkg::*;
	import video_pkg::*;

	// Five tests, each well under 1200 cycles
	localparam int TEST_COUNT      = 5;
	localparam int CYCLES_PER_TEST = 1200;
	localparam int TIMEOUT_CYCLES  = TEST_COUNT * CYCLES_PER_TEST;

	logic              clk_sys;
	logic              rst_n;
	player_in_s  [1:0] players;
	player_cfg_s [1:0] cfg;
	logic              dspeed_fast;
	spin_speed_e       sspeed;
	logic              player2;
	logic              two_player_layout;
	logic              scandoubler;
	logic              hsync;
	logic              vsync;
	logic              pad_en_n;
	scan_pos_s         scan;
	logic              video;
	logic              pad_out;
	rgb_s              rgb;
	logic              hblank;
	logic              vblank;

	// Model of line count and positions
	logic [7:0] model_line;
	int         model_dig [2];
	int         model_spin [2];
	logic       checking;
	string      test_name;
	int         cycle_cnt = 0;

	breakout_control_top DUT (
		.clk_sys, .rst_n, .players, .cfg, .dspeed_fast, .sspeed, .player2,
		.two_player_layout, .scandoubler, .hsync, .vsync, .pad_en_n, .scan, .video,
		.pad_out, .rgb, .hblank, .vblank
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic int clamp_pos(input int value);
		if (value < 0) return 0;
		else if (value > 255) return 255;
		else return value;
	endfunction

	function automatic logic in_range(input int value, input int lo, input int hi);
		return (value >= lo) && (value <= hi);
	endfunction

	// Position that the selected source gives one channel
	function automatic int chan_position(input int ch);
		logic [7:0] ob_x;
		logic [7:0] ob_y;
		logic [7:0] pos8;
		ob_x = players[ch].stick_x ^ 8'h80;
		ob_y = players[ch].stick_y ^ 8'h80;
		pos8 = 8'd128;
		case (cfg[ch].mode)
			CTRL_DIGITAL: return model_dig[ch];
			CTRL_SPINNER: return model_spin[ch];
			// Absolute sources complemented unless inverted
			CTRL_STICK_X: pos8 = cfg[ch].invert ? ob_x : ~ob_x;
			CTRL_STICK_Y: pos8 = cfg[ch].invert ? ob_y : ~ob_y;
			CTRL_PADDLE:  pos8 = cfg[ch].invert ? players[ch].paddle : ~players[ch].paddle;
			default:      pos8 = 8'd128;
		endcase
		return int'(pos8);
	endfunction

	// Expected {pad_out, rgb, hblank, vblank}
	function automatic logic [14:0] ref_model();
		int          h;
		int          v;
		logic        pad;
		logic [11:0] colour;
		logic        hb;
		logic        vb;
		logic        tp;
		h   = scan.hcnt;
		v   = scan.vcnt;
		tp  = two_player_layout;
		pad = int'(model_line) < chan_position(player2 ? 1 : 0);
		if (!video) colour = 12'h000;
		else if (in_range(h, 64, 71) || (tp && in_range(h, 184, 191))) colour = 12'hA21;
		else if (in_range(h, 72, 79) || (tp && in_range(h, 176, 183))) colour = 12'hC81;
		else if (in_range(h, 80, 87) || (tp && in_range(h, 168, 175))) colour = 12'h173;
		else if (in_range(h, 88, 95) || (tp && in_range(h, 160, 167))) colour = 12'hCC3;
		else if (!tp && in_range(h, 211, 219)) colour = 12'h17C;
		else colour = 12'hFFF;
		// Player-2 screen is shifted right
		if (tp && player2) hb = (h >= 232) || (h <= 32);
		else hb = (h >= 224) || (h <= 24);
		vb = scandoubler ? in_range(v, 223, 252) : in_range(v, 228, 251);
		return {pad, colour, hb, vb};
	endfunction

	task automatic check_eq(input string name, input logic [31:0] expected,
	                        input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "Value mismatch in %s", name);
		end
	endtask

	// Outputs settle within the cycle, so look at the falling edge
	always @(negedge clk_sys) begin
		if (checking) check_eq(test_name, 32'(ref_model()), 32'({pad_out, rgb, hblank, vblank}));
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("The run timed out after %0d cycles", cycle_cnt);
			$display("STATUS: FAIL");
			$fatal(1, "Timeout");
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////

	// Inputs change 1 unit after the rising edge
	task automatic wait_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	// One frame, digital move lands on the edge where vsync is first high
	task automatic apply_vsync();
		int ch;
		int step;
		ch   = player2 ? 1 : 0;
		step = dspeed_fast ? 8 : 4;
		vsync = 1'b1;
		@(posedge clk_sys);
		if (players[ch].left) model_dig[ch] = clamp_pos(model_dig[ch] + step);
		else if (players[ch].right) model_dig[ch] = clamp_pos(model_dig[ch] - step);
		#1;
		vsync = 1'b0;
		wait_cycle();
	endtask

	// One spinner report on the active channel
	task automatic apply_spin(input logic [7:0] raw);
		int   ch;
		int   value;
		int   mag;
		int   step;
		logic sub;
		ch    = player2 ? 1 : 0;
		value = $signed(raw);
		// Magnitude field is 7 bits wide
		mag = ((value < 0) ? -value : value) % 128;
		case (sspeed)
			SPIN_SLOW:   step = mag * 2;
			SPIN_MEDIUM: step = mag * 4;
			SPIN_FAST:   step = mag * 8;
			default:     step = mag;
		endcase
		// Clockwise subtracts, invert swaps
		sub = (raw[7] == 1'b0) ^ cfg[ch].invert;
		players[ch].spinner = {~players[ch].spinner[8], raw};
		@(posedge clk_sys);
		if (sub) model_spin[ch] = clamp_pos(model_spin[ch] - step);
		else model_spin[ch] = clamp_pos(model_spin[ch] + step);
		#1;
	endtask

	task automatic pulse_line();
		@(posedge clk_sys);
		#1;
		hsync = 1'b1;
		@(posedge clk_sys);
		model_line = model_line + 8'd1;
		#1;
		hsync = 1'b0;
	endtask

	// Open the pad window and count the lines with pad high
	task automatic measure_pad(input string name);
		int exp_len;
		int len;
		int n;
		exp_len  = chan_position(player2 ? 1 : 0);
		len      = 0;
		pad_en_n = 1'b0;
		@(posedge clk_sys);
		model_line = 8'd0;
		#1;
		pad_en_n = 1'b1;
		for (n = 0; n <= exp_len; n++) begin
			@(negedge clk_sys);
			if (pad_out) len++;
			pulse_line();
		end
		check_eq({name, " pad length"}, exp_len, len);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [7:0] spin_raw;
		int         m;
		int         inv;
		int         k;
		void'($urandom(32'h031c_d03f));
		rst_n             = 1'b0;
		players           = '0;
		cfg               = '0;
		dspeed_fast       = 1'b0;
		sspeed            = SPIN_SLOW;
		player2           = 1'b0;
		two_player_layout = 1'b0;
		scandoubler       = 1'b0;
		hsync             = 1'b0;
		vsync             = 1'b0;
		pad_en_n          = 1'b1;
		scan              = '0;
		video             = 1'b0;
		model_line        = 8'd0;
		model_dig         = '{128, 128};
		model_spin        = '{128, 128};
		checking          = 1'b0;
		test_name         = "reset";
		repeat (3) @(posedge clk_sys);
		#1;
		rst_n    = 1'b1;
		checking = 1'b1;

		// Reset position
		test_name = "reset position";
		measure_pad(test_name);

		// Digital, both steps and both limits
		test_name = "digital right slow";
		players[0].right = 1'b1;
		repeat (5) apply_vsync();
		players[0].right = 1'b0;
		check_eq(test_name, 108, model_dig[0]);
		measure_pad(test_name);
		test_name = "digital left fast";
		dspeed_fast = 1'b1;
		players[0].left  = 1'b1;
		players[0].right = 1'b1;
		repeat (20) apply_vsync();
		players[0].left  = 1'b0;
		players[0].right = 1'b0;
		check_eq(test_name, 255, model_dig[0]);
		measure_pad(test_name);
		// Inactive player presses are dropped
		test_name = "player 2 ignored";
		players[1].right = 1'b1;
		repeat (4) apply_vsync();
		players[1].right = 1'b0;

		// Absolute sources
		for (m = 0; m < 3; m++) begin
			for (inv = 0; inv < 2; inv++) begin
				test_name = $sformatf("analog mode %0d invert %0d", m + 1, inv);
				cfg[0].mode   = ctrl_mode_e'(m + 1);
				cfg[0].invert = inv[0];
				players[0].stick_x = 8'($urandom);
				players[0].stick_y = 8'($urandom);
				players[0].paddle  = 8'($urandom);
				measure_pad(test_name);
			end
		end

		// Spinner, every speed, invert and sign with random magnitudes, then both limits
		test_name = "spinner random";
		cfg[0].mode = CTRL_SPINNER;
		for (k = 0; k < 16; k++) begin
			sspeed        = spin_speed_e'(k % 4);
			cfg[0].invert = k[2];
			spin_raw      = 8'($urandom);
			spin_raw[7]   = k[3];
			apply_spin(spin_raw);
		end
		measure_pad(test_name);
		test_name = "spinner floor";
		sspeed        = SPIN_FAST;
		cfg[0].invert = 1'b1;
		apply_spin(8'h81);
		check_eq(test_name, 0, model_spin[0]);
		measure_pad(test_name);
		test_name = "spinner ceiling";
		cfg[0].invert = 1'b0;
		apply_spin(8'h81);
		check_eq(test_name, 255, model_spin[0]);
		measure_pad(test_name);

		// Player 2 routing, blanking and colours
		test_name = "player 2 routing";
		player2 = 1'b1;
		wait_cycle();
		measure_pad(test_name);
		test_name = "player 2 hblank";
		two_player_layout = 1'b1;
		scan = scan_pos_s'({8'd28, 8'd0});
		wait_cycle();
		scan = scan_pos_s'({8'd230, 8'd0});
		wait_cycle();
		test_name = "overlay random";
		repeat (120) begin
			scan              = scan_pos_s'(16'($urandom));
			video             = 1'($urandom_range(1, 0));
			two_player_layout = 1'($urandom_range(1, 0));
			scandoubler       = 1'($urandom_range(1, 0));
			player2           = 1'($urandom_range(1, 0));
			wait_cycle();
		end

		checking = 1'b0;
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/breakout_control_top.sv
`default_nettype none

module breakout_control_top (
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  control_pkg::player_in_s  [1:0] players,
	input  control_pkg::player_cfg_s [1:0] cfg,
	input  logic                           dspeed_fast,
	input  control_pkg::spin_speed_e       sspeed,
	input  logic                           player2,
	input  logic                           two_player_layout,
	input  logic                           scandoubler,
	input  logic                           hsync,
	input  logic                           vsync,
	input  logic                           pad_en_n,
	input  video_pkg::scan_pos_s           scan,
	input  logic                           video,
	output logic                           pad_out,
	output video_pkg::rgb_s                rgb,
	output logic                           hblank,
	output logic                           vblank
);
	import control_pkg::*;

	chan_evt_s [1:0] evt;
	logic [7:0]      line_cnt;
	logic [1:0]      pads;

	////////////////////////////////////////////////////////////
	// Input stage, two player channels, video stage
	////////////////////////////////////////////////////////////

	input_front u_front (
		.clk_sys, .rst_n, .players, .player2, .hsync, .vsync, .pad_en_n,
		.evt, .line_cnt
	);

	for (genvar i = 0; i < 2; i++) begin : g_chan
		paddle_channel u_chan (
			.clk_sys, .rst_n, .player(players[i]), .cfg(cfg[i]), .dspeed_fast, .sspeed,
			.evt(evt[i]), .line_cnt, .pad(pads[i])
		);
	end

	video_overlay u_overlay (
		.pads, .player2, .two_player_layout, .scandoubler, .scan, .video,
		.pad_out, .rgb, .hblank, .vblank
	);

endmodule

`default_nettype wire

//--- source/control_pkg.sv
`default_nettype none

package control_pkg;

	////////////////////////////////////////////////////////////
	// Control selection
	////////////////////////////////////////////////////////////

	// Position source of one player
	typedef enum logic [2:0] {
		CTRL_DIGITAL,
		CTRL_STICK_X,
		CTRL_STICK_Y,
		CTRL_PADDLE,
		CTRL_SPINNER
	} ctrl_mode_e;

	// Spinner gain as a left shift of the magnitude
	typedef enum logic [1:0] {
		SPIN_SLOW,      // x2
		SPIN_MEDIUM,    // x4
		SPIN_FAST,      // x8
		SPIN_UNITY
	} spin_speed_e;

	////////////////////////////////////////////////////////////
	// Per-player bundles
	////////////////////////////////////////////////////////////

	// Raw controller inputs of one player
	typedef struct packed {
		logic       right;
		logic       left;
		logic [7:0] stick_x;    // signed
		logic [7:0] stick_y;    // signed
		logic [7:0] paddle;
		logic [8:0] spinner;    // toggle, sign, magnitude
	} player_in_s;

	typedef struct packed {
		ctrl_mode_e mode;
		logic       invert;
	} player_cfg_s;

	// Events from the input stage to one channel
	typedef struct packed {
		logic       enable;
		logic       vsync_rise;
		logic       spin_cw;
		logic       spin_ccw;
		logic [6:0] spin_mag;   // absolute value
	} chan_evt_s;

endpackage

`default_nettype wire

//--- source/input_front.sv
`default_nettype none

module input_front (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  control_pkg::player_in_s [1:0] players,
	input  logic                          player2,
	input  logic                          hsync,
	input  logic                          vsync,
	input  logic                          pad_en_n,
	output control_pkg::chan_evt_s  [1:0] evt,
	output logic [7:0]                    line_cnt
);
	import control_pkg::*;

	logic            hsync_q;
	logic            vsync_q;
	logic [1:0]      spin_tog_q;
	logic            hsync_rise;
	logic            vsync_rise;
	logic [1:0]      chan_en;
	logic [1:0]      spin_tog;
	logic [1:0][6:0] spin_abs;

	////////////////////////////////////////////////////////////
	// Sync and spinner history
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hsync_q    <= 1'b0;
			vsync_q    <= 1'b0;
			spin_tog_q <= 2'b00;
		end else begin
			hsync_q    <= hsync;
			vsync_q    <= vsync;
			spin_tog_q <= {players[1].spinner[8], players[0].spinner[8]};
		end
	end

	// Edge seen while the new level is at the input
	assign hsync_rise = hsync & ~hsync_q;
	assign vsync_rise = vsync & ~vsync_q;

	// Only the player at the table gets moves
	assign chan_en = {player2, ~player2};

	////////////////////////////////////////////////////////////
	// Per-channel events
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < 2; i++) begin : g_evt
		// Any change of bit 8 is one spinner report
		assign spin_tog[i] = players[i].spinner[8] ^ spin_tog_q[i];

		// Sign and two's-complement bits to absolute value
		assign spin_abs[i] = players[i].spinner[7] ? (~players[i].spinner[6:0] + 7'd1)
		                                           : players[i].spinner[6:0];

		// Sign bit picks the direction, invert is left to the channel
		assign evt[i] = chan_evt_s'{
			enable:     chan_en[i],
			vsync_rise: vsync_rise,
			spin_cw:    spin_tog[i] & ~players[i].spinner[7] & chan_en[i],
			spin_ccw:   spin_tog[i] &  players[i].spinner[7] & chan_en[i],
			spin_mag:   spin_abs[i]
		};

		// One direction per report, and only when bit 8 moved since the last clock
		a_spin_dir_excl: assert property (@(posedge clk_sys) disable iff (!rst_n)
			(evt[i].spin_cw || evt[i].spin_ccw) |->
			(players[i].spinner[8] != $past(players[i].spinner[8])) &&
			!(evt[i].spin_cw && evt[i].spin_ccw));
	end

	////////////////////////////////////////////////////////////
	// Line counter
	////////////////////////////////////////////////////////////

	// Held at zero until the pad window opens, wraps at 256
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			line_cnt <= 8'd0;
		end else if (!pad_en_n) begin
			line_cnt <= 8'd0;
		end else if (hsync_rise) begin
			line_cnt <= line_cnt + 8'd1;
		end
	end

endmodule

`default_nettype wire

//--- source/paddle_channel.sv
`default_nettype none

`include "paddle_config.svh"

module paddle_channel (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  control_pkg::player_in_s  player,
	input  control_pkg::player_cfg_s cfg,
	input  logic                     dspeed_fast,
	input  control_pkg::spin_speed_e sspeed,
	input  control_pkg::chan_evt_s   evt,
	input  logic [7:0]               line_cnt,
	output logic                     pad
);
	import control_pkg::*;

	logic [8:0]  pos_dig;
	logic [8:0]  pos_spin;
	logic [3:0]  dstep;
	logic [8:0]  dig_up;
	logic [8:0]  dig_dn;
	logic [9:0]  spin_step;
	logic [10:0] spin_up;
	logic [10:0] spin_dn;
	logic        spin_sub;
	logic        spin_add;
	logic [7:0]  stick_x_ob;
	logic [7:0]  stick_y_ob;
	logic [7:0]  pos_sel;

	////////////////////////////////////////////////////////////
	// Digital accumulator
	////////////////////////////////////////////////////////////

	assign dstep  = dspeed_fast ? 4'(`DIGITAL_STEP_FAST) : 4'(`DIGITAL_STEP_SLOW);
	assign dig_up = pos_dig + 9'(dstep);
	assign dig_dn = pos_dig - 9'(dstep);

	// One step per frame, left has priority
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			pos_dig <= 9'(`PADDLE_POS_RESET);
		end else if (evt.enable && evt.vsync_rise) begin
			if (player.left) begin
				pos_dig <= (dig_up > 9'(`PADDLE_POS_MAX)) ? 9'(`PADDLE_POS_MAX) : dig_up;
			end else if (player.right) begin
				// Borrow into bit 8 means below zero
				pos_dig <= dig_dn[8] ? 9'd0 : dig_dn;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Spinner accumulator
	////////////////////////////////////////////////////////////

	always_comb begin
		spin_step = 10'(evt.spin_mag);
		case (sspeed)
			SPIN_SLOW:   spin_step = 10'(evt.spin_mag) << 1;
			SPIN_MEDIUM: spin_step = 10'(evt.spin_mag) << 2;
			SPIN_FAST:   spin_step = 10'(evt.spin_mag) << 3;
			SPIN_UNITY:  spin_step = 10'(evt.spin_mag);
		endcase
	end

	// Invert swaps the sense of rotation
	assign spin_sub = cfg.invert ? evt.spin_ccw : evt.spin_cw;
	assign spin_add = cfg.invert ? evt.spin_cw : evt.spin_ccw;
	assign spin_up  = 11'(pos_spin) + 11'(spin_step);
	assign spin_dn  = 11'(pos_spin) - 11'(spin_step);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			pos_spin <= 9'(`PADDLE_POS_RESET);
		end else if (spin_add) begin
			pos_spin <= (spin_up > 11'(`PADDLE_POS_MAX)) ? 9'(`PADDLE_POS_MAX) : spin_up[8:0];
		end else if (spin_sub) begin
			pos_spin <= spin_dn[10] ? 9'd0 : spin_dn[8:0];
		end
	end

	a_pos_in_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(pos_dig <= 9'(`PADDLE_POS_MAX)) && (pos_spin <= 9'(`PADDLE_POS_MAX)));

	////////////////////////////////////////////////////////////
	// Source select and pad compare
	////////////////////////////////////////////////////////////

	// Flip the sign bit for offset binary
	assign stick_x_ob = {~player.stick_x[7], player.stick_x[6:0]};
	assign stick_y_ob = {~player.stick_y[7], player.stick_y[6:0]};

	// Absolute sources are complemented unless inverted
	always_comb begin
		case (cfg.mode)
			CTRL_DIGITAL: pos_sel = pos_dig[7:0];
			CTRL_STICK_X: pos_sel = cfg.invert ? stick_x_ob : ~stick_x_ob;
			CTRL_STICK_Y: pos_sel = cfg.invert ? stick_y_ob : ~stick_y_ob;
			CTRL_PADDLE:  pos_sel = cfg.invert ? player.paddle : ~player.paddle;
			CTRL_SPINNER: pos_sel = pos_spin[7:0];
			default:      pos_sel = 8'(`PADDLE_POS_RESET);
		endcase
	end

	// Pad stays up until the line count reaches the position
	assign pad = line_cnt < pos_sel;

endmodule

`default_nettype wire

//--- source/video_overlay.sv
`default_nettype none

`include "paddle_config.svh"

module video_overlay (
	input  logic                  [1:0] pads,
	input  logic                        player2,
	input  logic                        two_player_layout,
	input  logic                        scandoubler,
	input  video_pkg::scan_pos_s        scan,
	input  logic                        video,
	output logic                        pad_out,
	output video_pkg::rgb_s             rgb,
	output logic                        hblank,
	output logic                        vblank
);
	import video_pkg::*;

	logic red_row;
	logic amber_row;
	logic green_row;
	logic yellow_row;
	logic blue_row;
	logic hblank_p1;
	logic hblank_p2;
	logic vblank_raw;
	logic vblank_fx;

	// Inclusive count window
	function automatic logic in_win(input logic [7:0] cnt, input logic [7:0] lo,
	                                input logic [7:0] hi);
		return (cnt >= lo) && (cnt <= hi);
	endfunction

	// Active player's pad back to the core
	assign pad_out = player2 ? pads[1] : pads[0];

	////////////////////////////////////////////////////////////
	// Brick row overlay
	////////////////////////////////////////////////////////////

	// Second wall of rows exists only in the two-player layout
	assign red_row    = in_win(scan.hcnt, `ROW_RED_P1_LO, `ROW_RED_P1_HI) ||
	                    (two_player_layout && in_win(scan.hcnt, `ROW_RED_P2_LO, `ROW_RED_P2_HI));
	assign amber_row  = in_win(scan.hcnt, `ROW_AMBER_P1_LO, `ROW_AMBER_P1_HI) ||
	                    (two_player_layout &&
	                     in_win(scan.hcnt, `ROW_AMBER_P2_LO, `ROW_AMBER_P2_HI));
	assign green_row  = in_win(scan.hcnt, `ROW_GREEN_P1_LO, `ROW_GREEN_P1_HI) ||
	                    (two_player_layout &&
	                     in_win(scan.hcnt, `ROW_GREEN_P2_LO, `ROW_GREEN_P2_HI));
	assign yellow_row = in_win(scan.hcnt, `ROW_YELLOW_P1_LO, `ROW_YELLOW_P1_HI) ||
	                    (two_player_layout &&
	                     in_win(scan.hcnt, `ROW_YELLOW_P2_LO, `ROW_YELLOW_P2_HI));
	assign blue_row   = !two_player_layout && in_win(scan.hcnt, `ROW_BLUE_LO, `ROW_BLUE_HI);

	// First matching row wins, plain video is white
	always_comb begin
		if (!video)          rgb = rgb_s'(12'h000);
		else if (red_row)    rgb = rgb_s'(12'hA21);
		else if (amber_row)  rgb = rgb_s'(12'hC81);
		else if (green_row)  rgb = rgb_s'(12'h173);
		else if (yellow_row) rgb = rgb_s'(12'hCC3);
		else if (blue_row)   rgb = rgb_s'(12'h17C);
		else                 rgb = rgb_s'(12'hFFF);
	end

	////////////////////////////////////////////////////////////
	// Blanking
	////////////////////////////////////////////////////////////

	// Window wraps through zero
	assign hblank_p1 = (scan.hcnt >= `HBLANK_P1_START) || (scan.hcnt <= `HBLANK_P1_END);
	assign hblank_p2 = (scan.hcnt >= `HBLANK_P2_START) || (scan.hcnt <= `HBLANK_P2_END);
	assign hblank    = (two_player_layout && player2) ? hblank_p2 : hblank_p1;

	// Wider window hides flicker behind the scandoubler
	assign vblank_raw = in_win(scan.vcnt, `VBLANK_RAW_LO, `VBLANK_RAW_HI);
	assign vblank_fx  = in_win(scan.vcnt, `VBLANK_FX_LO, `VBLANK_FX_HI);
	assign vblank     = scandoubler ? vblank_fx : vblank_raw;

endmodule

`default_nettype wire

//--- source/video_pkg.sv
`default_nettype none

package video_pkg;

	////////////////////////////////////////////////////////////
	// Video bundles
	////////////////////////////////////////////////////////////

	// 12-bit colour out of the overlay
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_s;

	// Beam position from the game core
	// hcnt runs across the screen, vcnt down it
	typedef struct packed {
		logic [7:0] hcnt;
		logic [7:0] vcnt;
	} scan_pos_s;

endpackage

`default_nettype wire
